/* logic/serial_pkg.sv */
package serial_pkg;

   localparam int XLEN      = 32;
   localparam int REG_COUNT = 32;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [4:0]      reg_addr_t;
   typedef logic [4:0]      bit_cnt_t;

   localparam word_t RESET_PC = 32'h0000_0000;

   // Executed major opcodes
   localparam logic [6:0] OPCODE_OP     = 7'b0110011;
   localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

   typedef logic [2:0] alu_sel_t;

   localparam alu_sel_t ALU_ADD  = 3'd0;
   localparam alu_sel_t ALU_SUB  = 3'd1;
   localparam alu_sel_t ALU_AND  = 3'd2;
   localparam alu_sel_t ALU_OR   = 3'd3;
   localparam alu_sel_t ALU_XOR  = 3'd4;
   localparam alu_sel_t ALU_SLT  = 3'd5;
   localparam alu_sel_t ALU_SLTU = 3'd6;

   typedef enum logic [1:0] {
      FETCH,
      EXECUTE,
      COMMIT
   } seq_state_t;

endpackage

/* logic/serial_sequencer.sv */
`timescale 1ns/100ps

module serial_sequencer (
   input  logic                 clk,
   input  logic                 i_reset,
   input  logic                 i_ibus_ack,
   output logic                 o_ibus_cyc,
   output serial_pkg::word_t    o_ibus_adr,
   output logic                 o_fetch_done,
   output logic                 o_exec_en,
   output serial_pkg::bit_cnt_t o_bit_cnt,
   output logic                 o_first_bit,
   output logic                 o_commit
);

   serial_pkg::seq_state_t state;
   serial_pkg::bit_cnt_t   cnt;
   serial_pkg::word_t      pc;
   logic                   cyc;

   assign o_ibus_cyc   = cyc;
   assign o_ibus_adr   = pc;
   assign o_fetch_done = cyc & i_ibus_ack;
   assign o_exec_en    = (state == serial_pkg::EXECUTE);
   assign o_bit_cnt    = cnt;
   assign o_first_bit  = o_exec_en & (cnt == '0);
   assign o_commit     = (state == serial_pkg::COMMIT);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state <= serial_pkg::FETCH;
         cyc   <= 1'b0;
         cnt   <= '0;
         pc    <= serial_pkg::RESET_PC;
      end else begin
         case (state)
            serial_pkg::FETCH: begin
               // Bus cycle held until ack
               cyc <= ~o_fetch_done;
               cnt <= '0;
               if (o_fetch_done)
                  state <= serial_pkg::EXECUTE;
            end
            serial_pkg::EXECUTE: begin
               cnt <= cnt + 5'd1;
               if (cnt == serial_pkg::bit_cnt_t'(serial_pkg::XLEN - 1))
                  state <= serial_pkg::COMMIT;
            end
            default: begin
               pc    <= pc + 32'd4;
               cyc   <= 1'b1;
               state <= serial_pkg::FETCH;
            end
         endcase
      end
   end

   // No fetch while the datapath is busy
   a_cyc_idle: assert property (@(posedge clk) disable iff (i_reset)
      (state != serial_pkg::FETCH) |-> !o_ibus_cyc);

   a_commit_after_32: assert property (@(posedge clk) disable iff (i_reset)
      o_fetch_done |=> o_exec_en [*32] ##1 o_commit);

endmodule

/* logic/serial_decode.sv */
`timescale 1ns/100ps

module serial_decode (
   input  logic                  clk,
   input  logic                  i_reset,
   input  logic                  i_fetch_done,
   input  serial_pkg::word_t     i_ibus_rdt,
   input  serial_pkg::bit_cnt_t  i_bit_cnt,
   output serial_pkg::reg_addr_t o_rs1_addr,
   output serial_pkg::reg_addr_t o_rs2_addr,
   output serial_pkg::reg_addr_t o_rd_addr,
   output serial_pkg::alu_sel_t  o_alu_sel,
   output logic                  o_use_imm,
   output logic                  o_imm_bit,
   output logic                  o_rd_wen
);

   serial_pkg::word_t    instr;
   serial_pkg::word_t    imm;
   serial_pkg::alu_sel_t sel;
   logic [6:0]           opcode;
   logic [6:0]           funct7;
   logic [2:0]           funct3;
   logic                 f3_ok;
   logic                 valid;

   // Opcode zero after reset decodes as a no-op
   always_ff @(posedge clk) begin
      if (i_reset)
         instr <= '0;
      else if (i_fetch_done)
         instr <= i_ibus_rdt;
   end

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   assign o_rd_addr  = instr[11:7];
   assign o_rs1_addr = instr[19:15];
   assign o_rs2_addr = instr[24:20];

   always_comb begin
      f3_ok = 1'b1;
      case (funct3)
         3'b000:  sel = serial_pkg::ALU_ADD;
         3'b010:  sel = serial_pkg::ALU_SLT;
         3'b011:  sel = serial_pkg::ALU_SLTU;
         3'b100:  sel = serial_pkg::ALU_XOR;
         3'b110:  sel = serial_pkg::ALU_OR;
         3'b111:  sel = serial_pkg::ALU_AND;
         default: begin
            sel   = serial_pkg::ALU_ADD;
            f3_ok = 1'b0;
         end
      endcase

      valid = 1'b0;
      if (opcode == serial_pkg::OPCODE_OP) begin
         if (funct7 == 7'b0000000) begin
            valid = f3_ok;
         end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
            valid = 1'b1;
            sel   = serial_pkg::ALU_SUB;
         end
      end else if (opcode == serial_pkg::OPCODE_OP_IMM) begin
         // SUB-style upper bits retire as a no-op
         valid = f3_ok && (funct7 != 7'b0100000);
      end
   end

   assign o_alu_sel = sel;
   assign o_use_imm = (opcode == serial_pkg::OPCODE_OP_IMM);
   assign o_rd_wen  = valid && (o_rd_addr != '0);

   // Sign-extended I-type immediate, served LSB first
   assign imm       = {{20{instr[31]}}, instr[31:20]};
   assign o_imm_bit = imm[i_bit_cnt];

endmodule

/* logic/serial_alu.sv */
`timescale 1ns/100ps

module serial_alu (
   input  logic                 clk,
   input  logic                 i_reset,
   input  logic                 i_exec_en,
   input  logic                 i_first_bit,
   input  serial_pkg::alu_sel_t i_alu_sel,
   input  logic                 i_rs1_bit,
   input  logic                 i_rs2_bit,
   input  logic                 i_imm_bit,
   input  logic                 i_use_imm,
   output logic                 o_result_bit,
   output logic                 o_lt
);

   logic op_b;
   logic sub;
   logic b_add;
   logic carry_in;
   logic carry_r;
   logic sum;
   logic carry_out;
   logic lt_next;

   assign op_b = i_use_imm ? i_imm_bit : i_rs2_bit;

   // Compares run as a subtract
   assign sub = (i_alu_sel == serial_pkg::ALU_SUB) ||
                (i_alu_sel == serial_pkg::ALU_SLT) ||
                (i_alu_sel == serial_pkg::ALU_SLTU);

   assign b_add     = op_b ^ sub;
   assign carry_in  = i_first_bit ? sub : carry_r;
   assign sum       = i_rs1_bit ^ b_add ^ carry_in;
   assign carry_out = (i_rs1_bit & b_add) | (carry_in & (i_rs1_bit ^ b_add));

   always_comb begin
      case (i_alu_sel)
         serial_pkg::ALU_AND: o_result_bit = i_rs1_bit & op_b;
         serial_pkg::ALU_OR:  o_result_bit = i_rs1_bit | op_b;
         serial_pkg::ALU_XOR: o_result_bit = i_rs1_bit ^ op_b;
         serial_pkg::ALU_ADD,
         serial_pkg::ALU_SUB: o_result_bit = sum;
         default:             o_result_bit = 1'b0;
      endcase
   end

   // Sign bits decide when they differ, else borrow out
   assign lt_next = ((i_alu_sel == serial_pkg::ALU_SLT) && (i_rs1_bit != op_b)) ?
                    i_rs1_bit : ~carry_out;

   // Last step leaves the final compare in o_lt
   always_ff @(posedge clk) begin
      if (i_reset) begin
         carry_r <= 1'b0;
         o_lt    <= 1'b0;
      end else if (i_exec_en) begin
         carry_r <= carry_out;
         o_lt    <= lt_next;
      end
   end

   a_fresh_carry: assert property (@(posedge clk) disable iff (i_reset)
      i_first_bit |-> i_exec_en && !$past(i_exec_en));

endmodule

/* logic/serial_regfile.sv */
`timescale 1ns/100ps

module serial_regfile (
   input  logic                  clk,
   input  logic                  i_reset,
   input  logic                  i_exec_en,
   input  serial_pkg::bit_cnt_t  i_bit_cnt,
   input  logic                  i_commit,
   input  serial_pkg::reg_addr_t i_rs1_addr,
   input  serial_pkg::reg_addr_t i_rs2_addr,
   input  serial_pkg::reg_addr_t i_rd_addr,
   input  logic                  i_rd_wen,
   input  serial_pkg::alu_sel_t  i_alu_sel,
   input  logic                  i_result_bit,
   input  logic                  i_lt,
   output logic                  o_rs1_bit,
   output logic                  o_rs2_bit,
   output logic                  o_wb_valid,
   output serial_pkg::reg_addr_t o_wb_addr,
   output serial_pkg::word_t     o_wb_data
);

   serial_pkg::word_t regs [serial_pkg::REG_COUNT];
   serial_pkg::word_t result_sr;
   serial_pkg::word_t wr_data;
   logic              is_cmp;
   logic              wr_en;

   // x0 reads as zero
   assign o_rs1_bit = (i_rs1_addr != '0) && regs[i_rs1_addr][i_bit_cnt];
   assign o_rs2_bit = (i_rs2_addr != '0) && regs[i_rs2_addr][i_bit_cnt];

   // LSB enters first and ends up at bit 0
   always_ff @(posedge clk) begin
      if (i_exec_en)
         result_sr <= {i_result_bit, result_sr[serial_pkg::XLEN-1:1]};
   end

   assign is_cmp  = (i_alu_sel == serial_pkg::ALU_SLT) ||
                    (i_alu_sel == serial_pkg::ALU_SLTU);
   assign wr_data = is_cmp ? {31'd0, i_lt} : result_sr;
   assign wr_en   = i_commit & i_rd_wen;

   always_ff @(posedge clk) begin
      if (!i_reset && wr_en)
         regs[i_rd_addr] <= wr_data;
   end

   assign o_wb_valid = wr_en;
   assign o_wb_addr  = i_rd_addr;
   assign o_wb_data  = wr_data;

   // Decode must never hand over a write to x0
   a_no_x0_write: assert property (@(posedge clk) disable iff (i_reset)
      wr_en |-> (i_rd_addr != '0));

endmodule

/* logic/serial_core.sv */
`timescale 1ns/100ps

module serial_core (
   input  logic                  clk,
   input  logic                  i_reset,
   // Instruction bus
   output logic                  o_ibus_cyc,
   output serial_pkg::word_t     o_ibus_adr,
   input  logic                  i_ibus_ack,
   input  serial_pkg::word_t     i_ibus_rdt,
   // Commit port
   output logic                  o_wb_valid,
   output serial_pkg::reg_addr_t o_wb_addr,
   output serial_pkg::word_t     o_wb_data
);

   logic                   fetch_done;
   logic                   exec_en;
   serial_pkg::bit_cnt_t   bit_cnt;
   logic                   first_bit;
   logic                   commit;

   serial_pkg::reg_addr_t  rs1_addr;
   serial_pkg::reg_addr_t  rs2_addr;
   serial_pkg::reg_addr_t  rd_addr;
   serial_pkg::alu_sel_t   alu_sel;
   logic                   use_imm;
   logic                   imm_bit;
   logic                   rd_wen;

   logic                   rs1_bit;
   logic                   rs2_bit;
   logic                   result_bit;
   logic                   lt;

   serial_sequencer sequencer (
      .clk          (clk       ),
      .i_reset      (i_reset   ),
      .i_ibus_ack   (i_ibus_ack),
      .o_ibus_cyc   (o_ibus_cyc),
      .o_ibus_adr   (o_ibus_adr),
      .o_fetch_done (fetch_done),
      .o_exec_en    (exec_en   ),
      .o_bit_cnt    (bit_cnt   ),
      .o_first_bit  (first_bit ),
      .o_commit     (commit    )
   );

   serial_decode decode (
      .clk          (clk       ),
      .i_reset      (i_reset   ),
      .i_fetch_done (fetch_done),
      .i_ibus_rdt   (i_ibus_rdt),
      .i_bit_cnt    (bit_cnt   ),
      .o_rs1_addr   (rs1_addr  ),
      .o_rs2_addr   (rs2_addr  ),
      .o_rd_addr    (rd_addr   ),
      .o_alu_sel    (alu_sel   ),
      .o_use_imm    (use_imm   ),
      .o_imm_bit    (imm_bit   ),
      .o_rd_wen     (rd_wen    )
   );

   serial_alu alu (
      .clk          (clk       ),
      .i_reset      (i_reset   ),
      .i_exec_en    (exec_en   ),
      .i_first_bit  (first_bit ),
      .i_alu_sel    (alu_sel   ),
      .i_rs1_bit    (rs1_bit   ),
      .i_rs2_bit    (rs2_bit   ),
      .i_imm_bit    (imm_bit   ),
      .i_use_imm    (use_imm   ),
      .o_result_bit (result_bit),
      .o_lt         (lt        )
   );

   serial_regfile regfile (
      .clk          (clk       ),
      .i_reset      (i_reset   ),
      .i_exec_en    (exec_en   ),
      .i_bit_cnt    (bit_cnt   ),
      .i_commit     (commit    ),
      .i_rs1_addr   (rs1_addr  ),
      .i_rs2_addr   (rs2_addr  ),
      .i_rd_addr    (rd_addr   ),
      .i_rd_wen     (rd_wen    ),
      .i_alu_sel    (alu_sel   ),
      .i_result_bit (result_bit),
      .i_lt         (lt        ),
      .o_rs1_bit    (rs1_bit   ),
      .o_rs2_bit    (rs2_bit   ),
      .o_wb_valid   (o_wb_valid),
      .o_wb_addr    (o_wb_addr ),
      .o_wb_data    (o_wb_data )
   );

endmodule

/* tests/serial_core_checker.sv */
`timescale 1ns/100ps

module serial_core_checker (
   input  logic                  clk,
   input  logic                  i_reset,
   input  logic                  i_ibus_cyc,
   input  serial_pkg::word_t     i_ibus_adr,
   input  logic                  i_ibus_ack,
   input  serial_pkg::word_t     i_ibus_rdt,
   input  logic                  i_wb_valid,
   input  serial_pkg::reg_addr_t i_wb_addr,
   input  serial_pkg::word_t     i_wb_data,
   output int                    o_checked,
   output int                    o_errors
);

   localparam logic [6:0] OP_REG      = 7'b0110011;
   localparam logic [6:0] OP_IMM      = 7'b0010011;
   localparam int         COMMIT_AGE  = 33;
   localparam int         REFETCH_AGE = 34;

   serial_pkg::word_t     model [32];
   serial_pkg::word_t     exp_pc;
   serial_pkg::word_t     exp_data;
   serial_pkg::reg_addr_t exp_rd;
   logic                  exp_wen;
   int                    age;

   // Only the kept opcode/funct combinations write, and never x0
   function automatic logic writes_rd(serial_pkg::word_t instr);
      logic [6:0] f7;
      logic [2:0] f3;
      logic       f3_ok;
      logic       ok;
      f7 = instr[31:25];
      f3 = instr[14:12];
      f3_ok = (f3 != 3'b001) && (f3 != 3'b101);
      ok = 1'b0;
      if (instr[6:0] == OP_REG)
         ok = (f7 == 7'b0000000 && f3_ok) || (f7 == 7'b0100000 && f3 == 3'b000);
      else if (instr[6:0] == OP_IMM)
         ok = f3_ok && (f7 != 7'b0100000);
      return ok && (instr[11:7] != 5'd0);
   endfunction

   function automatic serial_pkg::word_t reference_result(serial_pkg::word_t instr,
                                                          serial_pkg::word_t a,
                                                          serial_pkg::word_t rs2_val);
      serial_pkg::word_t b;
      if (instr[6:0] == OP_IMM)
         b = {{20{instr[31]}}, instr[31:20]};
      else
         b = rs2_val;
      case (instr[14:12])
         3'b000:  return (instr[6:0] == OP_REG && instr[30]) ? a - b : a + b;
         3'b010:  return {31'd0, $signed(a) < $signed(b)};
         3'b011:  return {31'd0, a < b};
         3'b100:  return a ^ b;
         3'b110:  return a | b;
         3'b111:  return a & b;
         default: return '0;
      endcase
   endfunction

   task automatic flag_error(string msg);
      o_errors = o_errors + 1;
      $display("Error at %0t: %s", $time, msg);
   endtask

   task automatic accept_fetch();
      serial_pkg::word_t instr;
      instr = i_ibus_rdt;
      if (i_ibus_adr !== exp_pc)
         flag_error($sformatf("fetch address %h, expected %h", i_ibus_adr, exp_pc));
      exp_pc   = exp_pc + 32'd4;
      exp_wen  = writes_rd(instr);
      exp_rd   = instr[11:7];
      exp_data = reference_result(instr, model[instr[19:15]], model[instr[24:20]]);
      if (exp_wen)
         model[exp_rd] = exp_data;
      age = 0;
   endtask

   task automatic check_commit();
      if (exp_wen) begin
         if (!i_wb_valid)
            flag_error($sformatf("no commit 33 cycles after ack, expected x%0d", exp_rd));
         else if (i_wb_addr !== exp_rd || i_wb_data !== exp_data)
            flag_error($sformatf("commit x%0d = %h, expected x%0d = %h",
                                 i_wb_addr, i_wb_data, exp_rd, exp_data));
      end else if (i_wb_valid) begin
         flag_error($sformatf("commit to x%0d from an instruction that writes nothing",
                              i_wb_addr));
      end
   endtask

   // Age counts cycles since the last ack
   always @(posedge clk) begin
      if (i_reset) begin
         exp_pc    = 32'h0000_0000;
         exp_data  = '0;
         exp_rd    = '0;
         exp_wen   = 1'b0;
         age       = -1;
         o_checked = 0;
         o_errors  = 0;
         for (int i = 0; i < 32; i++)
            model[i] = '0;
      end else begin
         if (age >= 0)
            age = age + 1;
         if (age == COMMIT_AGE)
            check_commit();
         else if (i_wb_valid)
            flag_error($sformatf("unexpected commit to x%0d", i_wb_addr));
         if (age >= 1 && age < REFETCH_AGE && i_ibus_cyc)
            flag_error("bus cycle raised while an instruction is executing");
         if (age == REFETCH_AGE) begin
            if (!i_ibus_cyc)
               flag_error("next fetch did not start 34 cycles after ack");
            o_checked = o_checked + 1;
            age = -1;
         end
         if (age < 0 && i_ibus_cyc && i_ibus_ack)
            accept_fetch();
      end
   end

endmodule

/* tests/serial_core_tb.sv */
`timescale 1ns/100ps

module serial_core_tb;

   localparam int          NUM_TESTS  = 200;
   localparam int          SEED_COUNT = 31;
   localparam int          RESET_LEN  = 10;
   localparam logic [31:0] SEED       = 32'hf325bded;
   localparam logic [6:0]  OP_REG     = 7'b0110011;
   localparam logic [6:0]  OP_IMM     = 7'b0010011;

   logic                  clk;
   logic                  reset;
   logic                  ibus_cyc;
   serial_pkg::word_t     ibus_adr;
   logic                  ibus_ack;
   serial_pkg::word_t     ibus_rdt;
   logic                  wb_valid;
   serial_pkg::reg_addr_t wb_addr;
   serial_pkg::word_t     wb_data;
   int                    checked;
   int                    errors;

   serial_pkg::word_t     program_mem [NUM_TESTS];
   logic [31:0]           rng;

   serial_core UUT (
      .clk        (clk     ),
      .i_reset    (reset   ),
      .o_ibus_cyc (ibus_cyc),
      .o_ibus_adr (ibus_adr),
      .i_ibus_ack (ibus_ack),
      .i_ibus_rdt (ibus_rdt),
      .o_wb_valid (wb_valid),
      .o_wb_addr  (wb_addr ),
      .o_wb_data  (wb_data )
   );

   serial_core_checker scoreboard (
      .clk        (clk     ),
      .i_reset    (reset   ),
      .i_ibus_cyc (ibus_cyc),
      .i_ibus_adr (ibus_adr),
      .i_ibus_ack (ibus_ack),
      .i_ibus_rdt (ibus_rdt),
      .i_wb_valid (wb_valid),
      .i_wb_addr  (wb_addr ),
      .i_wb_data  (wb_data ),
      .o_checked  (checked ),
      .o_errors   (errors  )
   );

   function automatic logic [31:0] xorshift32(logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function logic [31:0] next_random();
      rng = xorshift32(rng);
      return rng;
   endfunction

   function automatic logic [2:0] pick_funct3(logic [2:0] r);
      case (r)
         3'd0, 3'd1: return 3'b000;
         3'd2:       return 3'b010;
         3'd3:       return 3'b011;
         3'd4:       return 3'b100;
         3'd5:       return 3'b110;
         default:    return 3'b111;
      endcase
   endfunction

   function automatic serial_pkg::word_t encode_r(logic [6:0] f7, serial_pkg::reg_addr_t rs2,
                                                  serial_pkg::reg_addr_t rs1, logic [2:0] f3,
                                                  serial_pkg::reg_addr_t rd);
      return {f7, rs2, rs1, f3, rd, OP_REG};
   endfunction

   function automatic serial_pkg::word_t encode_i(logic [11:0] imm, serial_pkg::reg_addr_t rs1,
                                                  logic [2:0] f3, serial_pkg::reg_addr_t rd);
      return {imm, rs1, f3, rd, OP_IMM};
   endfunction

   // x1..x31 get ADDI seeds first, then a random mix
   task automatic build_program();
      logic [31:0]           r;
      logic [31:0]           r2;
      serial_pkg::reg_addr_t rd;
      serial_pkg::reg_addr_t rs1;
      serial_pkg::reg_addr_t rs2;
      logic [2:0]            f3;
      for (int n = 0; n < NUM_TESTS; n++) begin
         r   = next_random();
         r2  = next_random();
         rd  = r[4:0];
         rs1 = r[9:5];
         rs2 = r[14:10];
         f3  = pick_funct3(r[18:16]);
         if (n < SEED_COUNT) begin
            program_mem[n] = encode_i(r2[11:0], 5'd0, 3'b000, serial_pkg::reg_addr_t'(n + 1));
         end else begin
            case (r[23:21])
               3'd0: program_mem[n] = encode_i(r2[11:0], 5'd0, 3'b000, rd);
               3'd1: program_mem[n] = encode_r(7'b0100000, rs2, rs1, 3'b000, rd);
               3'd2: program_mem[n] = encode_r(7'b0000000, rs2, rs1, f3, rd);
               3'd3: program_mem[n] = encode_i(r2[11:0], rs1, f3, rd);
               // Equal operands for the compares
               3'd4: program_mem[n] = encode_r(7'b0000000, rs1, rs1,
                                               r[24] ? 3'b010 : 3'b011, rd);
               3'd5: program_mem[n] = encode_r(7'b0000000, rs2, rs1, f3, 5'd0);
               // LUI or branch encodings retire as no-ops
               3'd6: program_mem[n] = {r2[31:7], r[25] ? 7'b0110111 : 7'b1100011};
               default: program_mem[n] = encode_r(7'b0000000, rs2, 5'd0, f3, rd);
            endcase
         end
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin
      int delay;
      rng      = SEED;
      reset    = 1'b1;
      ibus_ack = 1'b0;
      ibus_rdt = '0;
      build_program();
      repeat (RESET_LEN) @(negedge clk);
      reset = 1'b0;
      // Instruction memory answers each cycle after 0 to 3 cycles
      for (int n = 0; n < NUM_TESTS; n++) begin
         while (!ibus_cyc)
            @(negedge clk);
         delay = int'(next_random() % 32'd4);
         repeat (delay) @(negedge clk);
         ibus_ack = 1'b1;
         ibus_rdt = program_mem[n];
         @(negedge clk);
         ibus_ack = 1'b0;
         ibus_rdt = '0;
      end
      wait (checked == NUM_TESTS);
      repeat (2) @(posedge clk);
      $display("Instructions checked: %0d, errors: %0d", checked, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

   // Each instruction needs at most 37 cycles
   initial begin
      repeat (RESET_LEN + NUM_TESTS * 60) @(posedge clk);
      $display("Timeout: only %0d of %0d instructions finished in time", checked, NUM_TESTS);
      $display("Simulation failed");
      $finish;
   end

endmodule

/* serial_core.f */
logic/serial_pkg.sv
logic/serial_sequencer.sv
logic/serial_decode.sv
logic/serial_alu.sv
logic/serial_regfile.sv
logic/serial_core.sv
tests/serial_core_checker.sv
tests/serial_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module serial_core_tb \
   -f serial_core.f \
   -o serial_core_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/serial_core_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation run exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -q "^Simulation completed successfully$"; then
   exit 0
fi
exit 1
